// File: rtl/ext_pwr_ctrl.sv
// External power domain controller
// One sequencer and settle timer per domain, sharing a switch cell model

`timescale 1ns/1ps

module ext_pwr_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ext_pwr_pkg::domain_mask_t pwr_off_req_i,
  output ext_pwr_pkg::domain_mask_t pwr_off_ack_o,
  output ext_pwr_pkg::domain_mask_t domain_iso_o,
  output ext_pwr_pkg::domain_mask_t domain_rst_n_o,
  output ext_pwr_pkg::domain_mask_t domain_switch_on_o
);

  // Acknowledge from the switch cells
  ext_pwr_pkg::domain_mask_t switch_ack;

  // Sequencer to timer links
  ext_pwr_pkg::domain_mask_t settle_start;
  ext_pwr_pkg::domain_mask_t settle_done;

  for (genvar d = 0; d < ext_pwr_pkg::EXT_DOMAINS; d++) begin : gen_domain

    ext_pwr_seq seq_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .off_req_i      (pwr_off_req_i[d]),
      .off_ack_o      (pwr_off_ack_o[d]),
      .switch_ack_i   (switch_ack[d]),
      .settle_done_i  (settle_done[d]),
      .settle_start_o (settle_start[d]),
      .iso_o          (domain_iso_o[d]),
      .rst_n_o        (domain_rst_n_o[d]),
      .switch_on_o    (domain_switch_on_o[d])
    );

    pwr_settle_timer timer_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .start_i (settle_start[d]),
      .done_o  (settle_done[d])
    );

  end

  // Shared by all domains, one acknowledge bit each
  switch_cell_model switch_cell_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .switch_on_i  (domain_switch_on_o),
    .switch_ack_o (switch_ack)
  );

endmodule

// File: rtl/ext_pwr_pkg.sv
// External power domain controller package
// Domain count, sequencing latencies, shared vector types and FSM encoding

package ext_pwr_pkg;

  // Number of external power domains
  localparam int unsigned EXT_DOMAINS = 2;

  // Switch cells return their acknowledge this many cycles after a change
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

  // Settle time around isolation and reset
  localparam int unsigned SETTLE_CYCLES = 4;

  // Counter width able to hold SETTLE_CYCLES
  localparam int unsigned SETTLE_CNT_W = $clog2(SETTLE_CYCLES + 1);

  // One bit per external domain
  typedef logic [EXT_DOMAINS-1:0] domain_mask_t;

  // Settle interval counter
  typedef logic [SETTLE_CNT_W-1:0] settle_cnt_t;

  // Per-domain power sequencer states
  typedef enum logic [2:0] {
    PWR_ON,      // powered, isolation off
    PWR_ISO,     // isolation raised, settling
    PWR_RST,     // reset asserted
    PWR_SW_OFF,  // switch opened, waiting for cells
    PWR_OFF,     // fully off, ack high
    PWR_SW_ON,   // switch closed, waiting for cells
    PWR_UNRST    // reset released, settling before isolation drops
  } pwr_state_e;

endpackage

// File: rtl/ext_pwr_seq.sv
// Power-gating sequencer for one external domain
// Walks isolation, reset and power switch in order under a four-phase request

`timescale 1ns/1ps

module ext_pwr_seq (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic off_req_i,
  output logic off_ack_o,
  input  logic switch_ack_i,
  input  logic settle_done_i,
  output logic settle_start_o,
  output logic iso_o,
  output logic rst_n_o,
  output logic switch_on_o
);

  ext_pwr_pkg::pwr_state_e state_q;
  ext_pwr_pkg::pwr_state_e state_d;

  logic req_q;
  logic iso_d;
  logic rst_n_d;
  logic switch_on_d;
  logic off_ack_d;

  // Request is registered before the FSM looks at it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= off_req_i;
    end
  end

  // Requests are only honoured in PWR_ON and PWR_OFF
  always_comb begin
    state_d        = state_q;
    settle_start_o = 1'b0;
    case (state_q)
      ext_pwr_pkg::PWR_ON: begin
        if (req_q) begin
          state_d        = ext_pwr_pkg::PWR_ISO;
          settle_start_o = 1'b1;
        end
      end
      ext_pwr_pkg::PWR_ISO: begin
        if (settle_done_i) begin
          state_d = ext_pwr_pkg::PWR_RST;
        end
      end
      ext_pwr_pkg::PWR_RST: begin
        state_d = ext_pwr_pkg::PWR_SW_OFF;
      end
      ext_pwr_pkg::PWR_SW_OFF: begin
        // Cells report the domain is unpowered
        if (!switch_ack_i) begin
          state_d = ext_pwr_pkg::PWR_OFF;
        end
      end
      ext_pwr_pkg::PWR_OFF: begin
        if (!req_q) begin
          state_d = ext_pwr_pkg::PWR_SW_ON;
        end
      end
      ext_pwr_pkg::PWR_SW_ON: begin
        if (switch_ack_i) begin
          state_d        = ext_pwr_pkg::PWR_UNRST;
          settle_start_o = 1'b1;
        end
      end
      ext_pwr_pkg::PWR_UNRST: begin
        if (settle_done_i) begin
          state_d = ext_pwr_pkg::PWR_ON;
        end
      end
      default: begin
        state_d = ext_pwr_pkg::PWR_ON;
      end
    endcase
  end

  // Output values for the state being entered
  always_comb begin
    iso_d = (state_d != ext_pwr_pkg::PWR_ON);

    rst_n_d = !(state_d inside {ext_pwr_pkg::PWR_RST, ext_pwr_pkg::PWR_SW_OFF,
                                ext_pwr_pkg::PWR_OFF, ext_pwr_pkg::PWR_SW_ON});

    switch_on_d = !(state_d inside {ext_pwr_pkg::PWR_SW_OFF, ext_pwr_pkg::PWR_OFF});

    // Ack held until isolation drops at the end of power-on
    off_ack_d = (state_d inside {ext_pwr_pkg::PWR_OFF, ext_pwr_pkg::PWR_SW_ON,
                                 ext_pwr_pkg::PWR_UNRST});
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= ext_pwr_pkg::PWR_ON;
      iso_o       <= 1'b0;
      rst_n_o     <= 1'b1;
      switch_on_o <= 1'b1;
      off_ack_o   <= 1'b0;
    end else begin
      state_q     <= state_d;
      iso_o       <= iso_d;
      rst_n_o     <= rst_n_d;
      switch_on_o <= switch_on_d;
      off_ack_o   <= off_ack_d;
    end
  end

endmodule

// File: rtl/pwr_settle_timer.sv
// Settle interval timer
// Counts SETTLE_CYCLES from a start pulse and flags the end for one cycle

`timescale 1ns/1ps

module pwr_settle_timer (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic start_i,
  output logic done_o
);

  ext_pwr_pkg::settle_cnt_t cnt_q;

  // A start always reloads, even mid-count
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= ext_pwr_pkg::settle_cnt_t'(ext_pwr_pkg::SETTLE_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - ext_pwr_pkg::settle_cnt_t'(1);
    end
  end

  // Last count before idle
  assign done_o = (cnt_q == ext_pwr_pkg::settle_cnt_t'(1));

endmodule

// File: rtl/switch_cell_model.sv
// Power switch cell model
// Returns each domain's switch command as its acknowledge after a fixed delay

`timescale 1ns/1ps

module switch_cell_model (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ext_pwr_pkg::domain_mask_t switch_on_i,
  output ext_pwr_pkg::domain_mask_t switch_ack_o
);

  // One stage per cycle of latency
  ext_pwr_pkg::domain_mask_t stage_q [ext_pwr_pkg::SWITCH_ACK_LATENCY];

  // Domains come out of reset powered, so the chain starts at all ones
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ext_pwr_pkg::SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_on_i;
      for (int i = 1; i < ext_pwr_pkg::SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_o = stage_q[ext_pwr_pkg::SWITCH_ACK_LATENCY-1];

endmodule

// File: include/ext_pwr_tb_checks.svh
// Testbench checks for the external power controller
// Typed compare tasks and the expected domain controls per phase

`ifndef EXT_PWR_TB_CHECKS_SVH
`define EXT_PWR_TB_CHECKS_SVH

// Compare a full domain vector
task automatic check_mask(input string test_name,
                          input ext_pwr_pkg::domain_mask_t exp_val,
                          input ext_pwr_pkg::domain_mask_t act_val);
  if (act_val !== exp_val) begin
    $display("ERR %s: expected %b, actual %b", test_name, exp_val, act_val);
    $display("Result: FAILED");
    $fatal(1);
  end
endtask

// Compare a single control bit
task automatic check_bit(input string test_name,
                         input logic  exp_val,
                         input logic  act_val);
  if (act_val !== exp_val) begin
    $display("ERR %s: expected %b, actual %b", test_name, exp_val, act_val);
    $display("Result: FAILED");
    $fatal(1);
  end
endtask

// Expected {iso, rst_n, switch_on} for a domain at rest
function automatic logic [2:0] ref_domain_ctrl(input logic off_phase);
  logic [2:0] ctrl;
  if (off_phase) begin
    ctrl = 3'b100;
  end else begin
    ctrl = 3'b011;
  end
  return ctrl;
endfunction

`endif

// File: verif/tb_ext_pwr_ctrl.sv
// Testbench for the external power domain controller
// Runs request handshakes and checks sequencing order and domain state

`timescale 1ns/1ps

module tb_ext_pwr_ctrl;

  // About 20 handshakes of at most 50 cycles each, with margin
  localparam int unsigned TIMEOUT_CYCLES = 2000;
  localparam int unsigned OVERLAP_ROUNDS = 8;

  logic                      clk_i;
  logic                      rst_n_i;
  ext_pwr_pkg::domain_mask_t pwr_off_req_i;
  ext_pwr_pkg::domain_mask_t pwr_off_ack_o;
  ext_pwr_pkg::domain_mask_t domain_iso_o;
  ext_pwr_pkg::domain_mask_t domain_rst_n_o;
  ext_pwr_pkg::domain_mask_t domain_switch_on_o;

  // Expected phase per domain from our own requests (1 means off)
  ext_pwr_pkg::domain_mask_t exp_off;

  ext_pwr_pkg::domain_mask_t prev_iso;
  ext_pwr_pkg::domain_mask_t prev_rst_n;
  ext_pwr_pkg::domain_mask_t prev_sw;
  ext_pwr_pkg::domain_mask_t prev_ack;
  int unsigned               sw_fall_cyc [ext_pwr_pkg::EXT_DOMAINS];
  int unsigned               cycle_cnt;
  int                        seed;

  `include "ext_pwr_tb_checks.svh"

  ext_pwr_ctrl dut_i (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .pwr_off_req_i      (pwr_off_req_i),
    .pwr_off_ack_o      (pwr_off_ack_o),
    .domain_iso_o       (domain_iso_o),
    .domain_rst_n_o     (domain_rst_n_o),
    .domain_switch_on_o (domain_switch_on_o)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $fatal(1);
    end
  end

  // Edge-to-edge ordering of the domain controls
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      for (int d = 0; d < ext_pwr_pkg::EXT_DOMAINS; d++) begin
        if (!prev_iso[d] && domain_iso_o[d]) begin
          check_bit("off order iso from on", 1'b1, prev_rst_n[d] & prev_sw[d]);
        end
        if (prev_rst_n[d] && !domain_rst_n_o[d]) begin
          check_bit("off order iso before reset", 1'b1, prev_iso[d]);
        end
        if (prev_sw[d] && !domain_switch_on_o[d]) begin
          check_bit("off order reset before switch", 1'b0, prev_rst_n[d]);
          sw_fall_cyc[d] = cycle_cnt;
        end
        if (!prev_ack[d] && pwr_off_ack_o[d]) begin
          check_bit("ack latency", 1'b1,
                    (cycle_cnt - sw_fall_cyc[d]) >= ext_pwr_pkg::SWITCH_ACK_LATENCY);
        end
        if (!prev_sw[d] && domain_switch_on_o[d]) begin
          check_bit("on order switch under reset", 1'b0, prev_rst_n[d]);
        end
        if (!prev_rst_n[d] && domain_rst_n_o[d]) begin
          check_bit("on order switch before reset", 1'b1, prev_sw[d]);
        end
        if (prev_iso[d] && !domain_iso_o[d]) begin
          check_bit("on order reset before iso", 1'b1, prev_rst_n[d]);
          check_bit("on order ack with iso", 1'b0, pwr_off_ack_o[d]);
        end
        if (prev_ack[d] && !pwr_off_ack_o[d]) begin
          check_bit("ack fall with iso", 1'b0, domain_iso_o[d]);
        end
      end
    end
    prev_iso   <= domain_iso_o;
    prev_rst_n <= domain_rst_n_o;
    prev_sw    <= domain_switch_on_o;
    prev_ack   <= pwr_off_ack_o;
  end

  task automatic check_domain(input string test_name, input int d);
    logic [2:0] ctrl;
    ctrl = ref_domain_ctrl(exp_off[d]);
    check_bit({test_name, " iso"}, ctrl[2], domain_iso_o[d]);
    check_bit({test_name, " rst_n"}, ctrl[1], domain_rst_n_o[d]);
    check_bit({test_name, " switch"}, ctrl[0], domain_switch_on_o[d]);
  endtask

  task automatic check_all(input string test_name);
    ext_pwr_pkg::domain_mask_t exp_iso;
    ext_pwr_pkg::domain_mask_t exp_rst_n;
    ext_pwr_pkg::domain_mask_t exp_sw;
    logic [2:0]                ctrl;
    for (int d = 0; d < ext_pwr_pkg::EXT_DOMAINS; d++) begin
      ctrl         = ref_domain_ctrl(exp_off[d]);
      exp_iso[d]   = ctrl[2];
      exp_rst_n[d] = ctrl[1];
      exp_sw[d]    = ctrl[0];
    end
    check_mask({test_name, " iso"}, exp_iso, domain_iso_o);
    check_mask({test_name, " rst_n"}, exp_rst_n, domain_rst_n_o);
    check_mask({test_name, " switch"}, exp_sw, domain_switch_on_o);
  endtask

  // Called on a falling edge
  task automatic request_off(input int d);
    pwr_off_req_i[d] = 1'b1;
    while (pwr_off_ack_o[d] !== 1'b1) begin
      @(negedge clk_i);
    end
    exp_off[d] = 1'b1;
    check_domain("power off", d);
  endtask

  task automatic request_on(input int d);
    pwr_off_req_i[d] = 1'b0;
    while (pwr_off_ack_o[d] !== 1'b0) begin
      @(negedge clk_i);
    end
    exp_off[d] = 1'b0;
    check_domain("power on", d);
  endtask

  task automatic handshake(input int d, input int unsigned start_dly);
    repeat (start_dly) @(negedge clk_i);
    request_off(d);
    request_on(d);
  endtask

  initial begin
    int unsigned               delay [ext_pwr_pkg::EXT_DOMAINS];
    ext_pwr_pkg::domain_mask_t pick;
    seed          = 32'h333e0b0f;
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    pwr_off_req_i = '0;
    exp_off       = '0;
    cycle_cnt     = 0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_all("after reset");
    check_mask("after reset ack", '0, pwr_off_ack_o);

    // One domain at a time while the others stay on
    for (int d = 0; d < ext_pwr_pkg::EXT_DOMAINS; d++) begin
      request_off(d);
      check_all("single power off");
      request_on(d);
      check_all("single power on");
    end

    // Random domains with staggered, overlapping handshakes
    for (int r = 0; r < OVERLAP_ROUNDS; r++) begin
      pick = ext_pwr_pkg::domain_mask_t'($random(seed));
      // First round always runs every domain at once
      if (r == 0) begin
        pick = '1;
      end else if (pick == '0) begin
        pick[r % ext_pwr_pkg::EXT_DOMAINS] = 1'b1;
      end
      for (int d = 0; d < ext_pwr_pkg::EXT_DOMAINS; d++) begin
        delay[d] = $unsigned($random(seed)) % 12;
      end
      for (int d = 0; d < ext_pwr_pkg::EXT_DOMAINS; d++) begin
        automatic int dom = d;
        if (pick[dom]) begin
          fork
            handshake(dom, delay[dom]);
          join_none
        end
      end
      wait fork;
      @(negedge clk_i);
      check_all("overlap round");
    end

    repeat (2) @(negedge clk_i);
    if (pwr_off_ack_o !== '0 || pwr_off_req_i !== '0) begin
      $display("A request or ack is still high at the end of the run");
      $display("Result: FAILED");
      $fatal(1);
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

// File: vlog.f
+incdir+include
rtl/ext_pwr_pkg.sv
rtl/pwr_settle_timer.sv
rtl/ext_pwr_seq.sv
rtl/switch_cell_model.sv
rtl/ext_pwr_ctrl.sv
verif/tb_ext_pwr_ctrl.sv
